//--- hw/bus_pkg.sv
package bus_pkg;

	// width of every data word and byte address on the system bus.
	localparam int BUS_WIDTH = 32;

	// a word holds four bytes, so the two lowest address bits select a byte.
	localparam int BYTE_OFFSET_W = 2;

	typedef logic [BUS_WIDTH-1:0] word_t;
	typedef logic [BUS_WIDTH-1:0] addr_t;

endpackage

//--- hw/soc_map_pkg.sv
package soc_map_pkg;

	typedef logic [1:0] slave_idx_t;
	typedef logic [3:0] region_t;
	typedef logic [1:0] reg_off_t;

	localparam slave_idx_t SLV_SRAM  = 2'd0;
	localparam slave_idx_t SLV_GPIO  = 2'd1;
	localparam slave_idx_t SLV_TIMER = 2'd2;

	// address bits 15 to 12 pick the region, anything above must be zero.
	localparam int REGION_LSB = 12;
	localparam int REGION_MSB = 15;

	localparam region_t REGION_SRAM  = 4'h0;
	localparam region_t REGION_GPIO  = 4'h1;
	localparam region_t REGION_TIMER = 4'h2;

	// register offset inside the gpio and timer slaves.
	localparam int REG_OFF_LSB = 2;
	localparam int REG_OFF_MSB = 3;

	localparam reg_off_t GPIO_OUT  = 2'd0;
	localparam reg_off_t GPIO_IN   = 2'd1;
	localparam reg_off_t TMR_COUNT = 2'd0;
	localparam reg_off_t TMR_CTRL  = 2'd1;

endpackage

//--- hw/bus_ctrl.sv
`timescale 1ns/1ps

module bus_ctrl
	import bus_pkg::*;
	import soc_map_pkg::*;
#(
	parameter int NUM_SLAVES = 3
) (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  req_i,
	input  addr_t                 addr_i,
	input  logic                  we_i,
	input  word_t                 wdata_i,
	input  logic                  ack_i,
	input  word_t                 rdata_i,
	output logic                  busy_o,
	output logic                  done_o,
	output logic                  err_o,
	output word_t                 rdata_o,
	output addr_t                 bus_addr_o,
	output word_t                 bus_wdata_o,
	output logic                  bus_we_o,
	output logic [NUM_SLAVES-1:0] bus_select_o
);

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		DONE
	} ctrl_state_t;

	ctrl_state_t state;
	logic        mapped;
	slave_idx_t  slave_idx;

	// the region decode looks at the incoming request, not the registered copy.
	always_comb begin
		mapped    = 1'b0;
		slave_idx = SLV_SRAM;
		if (addr_i[BUS_WIDTH-1:REGION_MSB+1] == '0) begin
			case (region_t'(addr_i[REGION_MSB:REGION_LSB]))
				REGION_SRAM: begin
					mapped    = 1'b1;
					slave_idx = SLV_SRAM;
				end
				REGION_GPIO: begin
					mapped    = 1'b1;
					slave_idx = SLV_GPIO;
				end
				REGION_TIMER: begin
					mapped    = 1'b1;
					slave_idx = SLV_TIMER;
				end
				default: begin
					mapped = 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state        <= IDLE;
			bus_select_o <= '0;
			bus_we_o     <= 1'b0;
			err_o        <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req_i) begin
						bus_we_o <= we_i;
						err_o    <= ~mapped;
						if (mapped) begin
							bus_select_o <= {{(NUM_SLAVES-1){1'b0}}, 1'b1} << slave_idx;
							state        <= ACCESS;
						end else begin
							// unmapped requests skip the bus and finish next cycle.
							state <= DONE;
						end
					end
				end
				ACCESS: begin
					if (ack_i) begin
						bus_select_o <= '0;
						state        <= DONE;
					end
				end
				DONE: begin
					err_o <= 1'b0;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == IDLE && req_i) begin
			bus_addr_o  <= addr_i;
			bus_wdata_o <= wdata_i;
			if (!mapped) begin
				rdata_o <= '0;
			end
		end
		// writes report a zero word, reads the data of the slave.
		if (state == ACCESS && ack_i) begin
			rdata_o <= bus_we_o ? '0 : rdata_i;
		end
	end

	assign busy_o = (state != IDLE);
	assign done_o = (state == DONE);

	// the select is one-hot while the FSM waits for the ack and zero otherwise.
	a_select_onehot: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
			(state == ACCESS) ? $onehot(bus_select_o) : (bus_select_o == '0)
	);

	a_no_req_busy: assert property (
		@(posedge clk_i) disable iff (!rst_n_i) busy_o |-> !req_i
	);

endmodule

//--- hw/bus_master_if.sv
`timescale 1ns/1ps

module bus_master_if
	import bus_pkg::*;
#(
	parameter int NUM_SLAVES = 3
) (
	input  logic                         clk_i,
	input  addr_t                        bus_addr_i,
	input  word_t                        bus_wdata_i,
	input  logic                         bus_we_i,
	input  logic  [NUM_SLAVES-1:0]       bus_select_i,
	input  word_t [NUM_SLAVES-1:0]       s_rdata_i,
	input  logic  [NUM_SLAVES-1:0]       s_ack_i,
	output word_t                        bus_rdata_o,
	output logic                         bus_ack_o,
	output addr_t                        s_addr_o,
	output word_t                        s_wdata_o,
	output logic                         s_we_o,
	output logic  [NUM_SLAVES-1:0]       s_select_o
);

	logic sel_valid;

	// address, data and write enable are shared, the select is per slave.
	assign s_addr_o   = bus_addr_i;
	assign s_wdata_o  = bus_wdata_i;
	assign s_we_o     = bus_we_i;
	assign s_select_o = bus_select_i;

	assign sel_valid = (bus_select_i != '0) &&
		((bus_select_i & (bus_select_i - 1'b1)) == '0);

	// only the selected slave may drive the return path.
	always_comb begin
		bus_rdata_o = '0;
		bus_ack_o   = 1'b0;
		if (sel_valid) begin
			for (int i = 0; i < NUM_SLAVES; i++) begin
				if (bus_select_i[i]) begin
					bus_rdata_o = s_rdata_i[i];
					bus_ack_o   = s_ack_i[i];
				end
			end
		end
	end

	a_ack_from_selected: assert property (
		@(posedge clk_i) (s_ack_i & ~bus_select_i) == '0
	);

endmodule

//--- hw/sram_slave.sv
`timescale 1ns/1ps

module sram_slave
	import bus_pkg::*;
#(
	parameter int SRAM_WORDS = 256,
	parameter int SRAM_WAIT  = 2
) (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  logic  sel_i,
	input  logic  we_i,
	input  addr_t addr_i,
	input  word_t wdata_i,
	output word_t rdata_o,
	output logic  ack_o
);

	localparam int IDX_W = $clog2(SRAM_WORDS);
	localparam int CNT_W = (SRAM_WAIT > 0) ? $clog2(SRAM_WAIT + 1) : 1;

	word_t            mem [SRAM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [CNT_W-1:0] wait_cnt;
	logic             acked;
	logic             fire;

	// upper address bits are dropped, so the region aliases every depth.
	assign idx  = addr_i[BYTE_OFFSET_W +: IDX_W];
	assign fire = sel_i && !acked && (wait_cnt == CNT_W'(SRAM_WAIT));

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o    <= 1'b0;
			wait_cnt <= '0;
			acked    <= 1'b0;
		end else begin
			ack_o <= fire;
			if (!sel_i) begin
				wait_cnt <= '0;
				acked    <= 1'b0;
			end else if (fire) begin
				acked <= 1'b1;
			end else if (!acked) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (fire) begin
			if (we_i) begin
				mem[idx] <= wdata_i;
			end
			rdata_o <= mem[idx];
		end
	end

endmodule

//--- hw/gpio_slave.sv
`timescale 1ns/1ps

module gpio_slave
	import bus_pkg::*;
	import soc_map_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  logic  sel_i,
	input  logic  we_i,
	input  addr_t addr_i,
	input  word_t wdata_i,
	input  word_t gpio_in_i,
	output word_t rdata_o,
	output logic  ack_o,
	output word_t gpio_out_o
);

	reg_off_t reg_off;
	logic     access;
	word_t    gpio_meta;
	word_t    gpio_sync;

	assign reg_off = addr_i[REG_OFF_MSB:REG_OFF_LSB];
	assign access  = sel_i & ~ack_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o      <= 1'b0;
			gpio_out_o <= '0;
		end else begin
			ack_o <= access;
			if (access && we_i && reg_off == GPIO_OUT) begin
				gpio_out_o <= wdata_i;
			end
		end
	end

	// the input pins are asynchronous, two flops before they reach the bus.
	always_ff @(posedge clk_i) begin
		gpio_meta <= gpio_in_i;
		gpio_sync <= gpio_meta;
		if (access) begin
			case (reg_off)
				GPIO_OUT: rdata_o <= gpio_out_o;
				GPIO_IN:  rdata_o <= gpio_sync;
				default:  rdata_o <= '0;
			endcase
		end
	end

endmodule

//--- hw/timer_slave.sv
`timescale 1ns/1ps

module timer_slave
	import bus_pkg::*;
	import soc_map_pkg::*;
(
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  logic  sel_i,
	input  logic  we_i,
	input  addr_t addr_i,
	input  word_t wdata_i,
	output word_t rdata_o,
	output logic  ack_o
);

	reg_off_t reg_off;
	logic     access;
	word_t    count;
	logic     enable;

	assign reg_off = addr_i[REG_OFF_MSB:REG_OFF_LSB];
	assign access  = sel_i & ~ack_o;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_o  <= 1'b0;
			count  <= '0;
			enable <= 1'b0;
		end else begin
			ack_o <= access;
			// a load wins over the increment in the same cycle.
			if (access && we_i && reg_off == TMR_COUNT) begin
				count <= wdata_i;
			end else if (enable) begin
				count <= count + 1'b1;
			end
			if (access && we_i && reg_off == TMR_CTRL) begin
				enable <= wdata_i[0];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			case (reg_off)
				TMR_COUNT: rdata_o <= count;
				TMR_CTRL:  rdata_o <= {{(BUS_WIDTH-1){1'b0}}, enable};
				default:   rdata_o <= '0;
			endcase
		end
	end

endmodule

//--- hw/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
	import bus_pkg::*;
	import soc_map_pkg::*;
#(
	parameter int NUM_SLAVES = 3,
	parameter int SRAM_WORDS = 256,
	parameter int SRAM_WAIT  = 2
) (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  logic  req_i,
	input  addr_t addr_i,
	input  logic  we_i,
	input  word_t wdata_i,
	input  word_t gpio_in_i,
	output logic  busy_o,
	output logic  done_o,
	output logic  err_o,
	output word_t rdata_o,
	output word_t gpio_out_o
);

	addr_t                  bus_addr;
	word_t                  bus_wdata;
	logic                   bus_we;
	logic  [NUM_SLAVES-1:0] bus_select;
	word_t                  bus_rdata;
	logic                   bus_ack;

	addr_t                  s_addr;
	word_t                  s_wdata;
	logic                   s_we;
	logic  [NUM_SLAVES-1:0] s_select;
	word_t [NUM_SLAVES-1:0] s_rdata;
	logic  [NUM_SLAVES-1:0] s_ack;

	bus_ctrl #(
		.NUM_SLAVES (NUM_SLAVES)
	) u_bus_ctrl (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.req_i        (req_i),
		.addr_i       (addr_i),
		.we_i         (we_i),
		.wdata_i      (wdata_i),
		.ack_i        (bus_ack),
		.rdata_i      (bus_rdata),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.err_o        (err_o),
		.rdata_o      (rdata_o),
		.bus_addr_o   (bus_addr),
		.bus_wdata_o  (bus_wdata),
		.bus_we_o     (bus_we),
		.bus_select_o (bus_select)
	);

	bus_master_if #(
		.NUM_SLAVES (NUM_SLAVES)
	) u_bus_master_if (
		.clk_i        (clk_i),
		.bus_addr_i   (bus_addr),
		.bus_wdata_i  (bus_wdata),
		.bus_we_i     (bus_we),
		.bus_select_i (bus_select),
		.s_rdata_i    (s_rdata),
		.s_ack_i      (s_ack),
		.bus_rdata_o  (bus_rdata),
		.bus_ack_o    (bus_ack),
		.s_addr_o     (s_addr),
		.s_wdata_o    (s_wdata),
		.s_we_o       (s_we),
		.s_select_o   (s_select)
	);

	sram_slave #(
		.SRAM_WORDS (SRAM_WORDS),
		.SRAM_WAIT  (SRAM_WAIT)
	) u_sram_slave (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.sel_i   (s_select[SLV_SRAM]),
		.we_i    (s_we),
		.addr_i  (s_addr),
		.wdata_i (s_wdata),
		.rdata_o (s_rdata[SLV_SRAM]),
		.ack_o   (s_ack[SLV_SRAM])
	);

	gpio_slave u_gpio_slave (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.sel_i      (s_select[SLV_GPIO]),
		.we_i       (s_we),
		.addr_i     (s_addr),
		.wdata_i    (s_wdata),
		.gpio_in_i  (gpio_in_i),
		.rdata_o    (s_rdata[SLV_GPIO]),
		.ack_o      (s_ack[SLV_GPIO]),
		.gpio_out_o (gpio_out_o)
	);

	timer_slave u_timer_slave (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.sel_i   (s_select[SLV_TIMER]),
		.we_i    (s_we),
		.addr_i  (s_addr),
		.wdata_i (s_wdata),
		.rdata_o (s_rdata[SLV_TIMER]),
		.ack_o   (s_ack[SLV_TIMER])
	);

endmodule

//--- testbench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus
	import bus_pkg::*;
	import soc_map_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int SRAM_WORDS   = 256;
	localparam int SRAM_WAIT    = 2;
	localparam int SRAM_TESTS   = 24;
	localparam int BAD_TESTS    = 16;
	localparam int NUM_TXN      = 90;

	localparam addr_t GPIO_OUT_ADDR  = 32'h0000_1000;
	localparam addr_t GPIO_IN_ADDR   = 32'h0000_1004;
	localparam addr_t TMR_COUNT_ADDR = 32'h0000_2000;
	localparam addr_t TMR_CTRL_ADDR  = 32'h0000_2004;

	logic  clk_i;
	logic  rst_n_i;
	logic  req_i;
	addr_t addr_i;
	logic  we_i;
	word_t wdata_i;
	word_t gpio_in_i;
	logic  busy_o;
	logic  done_o;
	logic  err_o;
	word_t rdata_o;
	word_t gpio_out_o;

	// reference copy of the slave state.
	word_t ref_mem [SRAM_WORDS];
	word_t ref_gpio_out;
	word_t ref_gpio_in;
	logic  ref_tmr_en;
	word_t ref_tmr_count;
	logic  ref_count_known;

	word_t       exp_rdata;
	logic        exp_err;
	logic        exp_care;
	int          issued;
	int          compared;
	logic [31:0] rng_state;

	soc_bus_top #(
		.SRAM_WORDS (SRAM_WORDS),
		.SRAM_WAIT  (SRAM_WAIT)
	) dut (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.req_i      (req_i),
		.addr_i     (addr_i),
		.we_i       (we_i),
		.wdata_i    (wdata_i),
		.gpio_in_i  (gpio_in_i),
		.busy_o     (busy_o),
		.done_o     (done_o),
		.err_o      (err_o),
		.rdata_o    (rdata_o),
		.gpio_out_o (gpio_out_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_i = ~clk_i;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// 0, 1 and 2 are sram, gpio and timer, 3 stands for an unmapped address.
	function automatic int decode_region(input addr_t a);
		if (a[31:16] != 16'h0) begin
			return 3;
		end
		if (a[15:12] > 4'd2) begin
			return 3;
		end
		return int'(a[15:12]);
	endfunction

	// result is {compare rdata, err, rdata}.
	function automatic logic [33:0] model_access(input addr_t a, input logic we, input word_t wd);
		int    region;
		int    off;
		int    idx;
		word_t rd;
		logic  care;
		region = decode_region(a);
		off    = int'(a[3:2]);
		idx    = int'(a[31:2]) % SRAM_WORDS;
		rd     = '0;
		care   = 1'b1;
		if (region == 3) begin
			return {1'b1, 1'b1, 32'h0};
		end
		if (region == 0) begin
			if (we) begin
				ref_mem[idx] = wd;
			end else begin
				rd = ref_mem[idx];
			end
		end else if (region == 1) begin
			if (off == 0 && we) begin
				ref_gpio_out = wd;
			end else if (off == 0) begin
				rd = ref_gpio_out;
			end else if (off == 1 && !we) begin
				rd = ref_gpio_in;
			end
		end else begin
			if (off == 0 && we) begin
				ref_tmr_count   = wd;
				ref_count_known = !ref_tmr_en;
			end else if (off == 0) begin
				rd   = ref_tmr_count;
				care = ref_count_known;
			end else if (off == 1 && we) begin
				ref_tmr_en = wd[0];
				if (wd[0]) begin
					ref_count_known = 1'b0;
				end
			end else if (off == 1) begin
				rd = {31'h0, ref_tmr_en};
			end
		end
		return {care, 1'b0, rd};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		$display("Verification failed");
		$fatal(1, "stopping at the first mismatch");
	endtask

	task automatic report_problem(input string msg);
		$display("at %0t ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopping after an error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		assert (actual === expected) else report_mismatch(name, expected, actual);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_i);
	endtask

	// one request, held for a single cycle, then wait for done_o.
	task automatic bus_access(input addr_t a, input logic we, input word_t wd, output word_t rd);
		logic [33:0] expect_v;
		int          lat;
		int          exp_lat;
		int          region;
		@(posedge clk_i);
		region    = decode_region(a);
		expect_v  = model_access(a, we, wd);
		exp_care  = expect_v[33];
		exp_err   = expect_v[32];
		exp_rdata = expect_v[31:0];
		issued    = issued + 1;
		req_i   <= 1'b1;
		addr_i  <= a;
		we_i    <= we;
		wdata_i <= wd;
		@(negedge clk_i);
		assert (busy_o === 1'b0) else report_mismatch("busy_o", 32'd0, 32'(busy_o));
		@(posedge clk_i);
		req_i <= 1'b0;
		lat = 1;
		@(negedge clk_i);
		while (done_o !== 1'b1) begin
			assert (busy_o === 1'b1) else report_mismatch("busy_o", 32'd1, 32'(busy_o));
			if (lat > 20) begin
				report_problem("no done_o came within 20 cycles of a request");
			end
			@(posedge clk_i);
			lat = lat + 1;
			@(negedge clk_i);
		end
		assert (busy_o === 1'b1) else report_mismatch("busy_o", 32'd1, 32'(busy_o));
		rd = rdata_o;
		if (region == 3) begin
			exp_lat = 1;
		end else if (region == 0) begin
			exp_lat = 3 + SRAM_WAIT;
		end else begin
			exp_lat = 3;
		end
		assert (lat == exp_lat) else report_mismatch("latency", 32'(exp_lat), 32'(lat));
	endtask

	always @(negedge clk_i) begin
		if (rst_n_i && done_o) begin
			compared = compared + 1;
			assert (err_o === exp_err) else report_mismatch("err_o", 32'(exp_err), 32'(err_o));
			if (exp_care) begin
				assert (rdata_o === exp_rdata) else report_mismatch("rdata_o", exp_rdata, rdata_o);
			end
		end
	end

	initial begin
		#((NUM_TXN * 20 + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in time");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		word_t       rd;
		word_t       prev;
		addr_t       a;
		logic [31:0] r;
		int          written [$];
		rst_n_i         = 1'b0;
		req_i           = 1'b0;
		addr_i          = '0;
		we_i            = 1'b0;
		wdata_i         = '0;
		gpio_in_i       = '0;
		ref_gpio_out    = '0;
		ref_gpio_in     = '0;
		ref_tmr_en      = 1'b0;
		ref_tmr_count   = '0;
		ref_count_known = 1'b1;
		exp_rdata       = '0;
		exp_err         = 1'b0;
		exp_care        = 1'b0;
		issued          = 0;
		compared        = 0;
		rng_state       = 32'h70e65e76;
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_n_i <= 1'b1;

		for (int i = 0; i < SRAM_TESTS; i++) begin
			r = next_random();
			a = {20'h0, r[11:2], 2'b00};
			bus_access(a, 1'b1, next_random(), rd);
			written.push_back(int'(r[9:2]));
		end
		// bits 11 and 10 lie above the depth, so they pick another alias of the word.
		foreach (written[i]) begin
			r = next_random();
			a = {20'h0, r[11:10], 8'(written[i]), 2'b00};
			bus_access(a, 1'b0, '0, rd);
		end

		r = next_random();
		bus_access(GPIO_OUT_ADDR, 1'b1, r, rd);
		check_word("gpio_out_o", r, gpio_out_o);
		bus_access(GPIO_OUT_ADDR, 1'b0, '0, rd);
		@(posedge clk_i);
		r = next_random();
		gpio_in_i <= r;
		ref_gpio_in = r;
		wait_cycles(3);
		bus_access(GPIO_IN_ADDR, 1'b0, '0, rd);
		bus_access(GPIO_IN_ADDR, 1'b1, next_random(), rd);
		// the pins are unchanged, so the read must still show the old input value.
		bus_access(GPIO_IN_ADDR, 1'b0, '0, rd);
		@(posedge clk_i);
		r = next_random();
		gpio_in_i <= r;
		ref_gpio_in = r;
		wait_cycles(3);
		bus_access(GPIO_IN_ADDR, 1'b0, '0, rd);
		bus_access(GPIO_OUT_ADDR | 32'h8, 1'b0, '0, rd);
		bus_access(GPIO_OUT_ADDR | 32'hc, 1'b0, '0, rd);
		check_word("gpio_out_o", ref_gpio_out, gpio_out_o);

		bus_access(TMR_CTRL_ADDR, 1'b1, 32'h0, rd);
		r = next_random();
		r[31:24] = 8'h0;
		bus_access(TMR_COUNT_ADDR, 1'b1, r, rd);
		bus_access(TMR_COUNT_ADDR, 1'b0, '0, prev);
		bus_access(TMR_COUNT_ADDR, 1'b0, '0, rd);
		check_word("timer count", prev, rd);
		bus_access(TMR_CTRL_ADDR, 1'b1, 32'h1, rd);
		bus_access(TMR_CTRL_ADDR, 1'b0, '0, rd);
		bus_access(TMR_COUNT_ADDR, 1'b0, '0, prev);
		repeat (3) begin
			bus_access(TMR_COUNT_ADDR, 1'b0, '0, rd);
			assert (rd > prev) else
				report_problem($sformatf("timer count did not rise, %h then %h", prev, rd));
			prev = rd;
		end
		bus_access(TMR_CTRL_ADDR, 1'b1, 32'h0, rd);
		bus_access(TMR_COUNT_ADDR, 1'b0, '0, prev);
		bus_access(TMR_COUNT_ADDR, 1'b0, '0, rd);
		check_word("timer count", prev, rd);

		for (int i = 0; i < BAD_TESTS; i++) begin
			r = next_random();
			if (i % 2 == 0) begin
				a = {16'h0, r[15:0]};
				if (a[15:12] < 4'd3) begin
					a[15:12] = a[15:12] + 4'd3;
				end
			end else begin
				a = r;
				a[16 + int'(r[3:0])] = 1'b1;
			end
			bus_access(a, r[4], next_random(), rd);
		end
		bus_access(GPIO_OUT_ADDR, 1'b0, '0, rd);
		for (int i = 0; i < 4; i++) begin
			a = {20'h0, 2'b00, 8'(written[i]), 2'b00};
			bus_access(a, 1'b0, '0, rd);
		end

		wait_cycles(2);
		if (compared == issued) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("only %0d of %0d requests were checked on done_o", compared, issued);
			$display("Verification failed");
			$fatal(1, "completion count mismatch");
		end
	end

endmodule

//--- src.f
hw/bus_pkg.sv
hw/soc_map_pkg.sv
hw/bus_ctrl.sv
hw/bus_master_if.sv
hw/sram_slave.sv
hw/gpio_slave.sv
hw/timer_slave.sv
hw/soc_bus_top.sv
testbench/tb_soc_bus.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_soc_bus
FILELIST  := src.f
BUILD_DIR := obj_dir
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass line shows up in the simulator output.
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
